/* verilog/memreq_pkg.sv */
`default_nettype none

package memreq_pkg;

  localparam int ADDR_W    = 28;
  localparam int DATA_W    = 32;
  localparam int ID_W      = 4;
  localparam int HDR_BYTES = 8;

  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;
  localparam logic [1:0] RESP_BADCMD = 2'd3;

  // Command parser FSM states
  localparam logic [2:0] ST_HDR     = 3'd0;
  localparam logic [2:0] ST_ADDR    = 3'd1;
  localparam logic [2:0] ST_PAYLOAD = 3'd2;
  localparam logic [2:0] ST_DRAIN   = 3'd3;
  localparam logic [2:0] ST_BAD     = 3'd4;
  localparam logic [2:0] ST_WAIT    = 3'd5;

  // Header bytes in arrival order with byte 0 in bits 7:0
  typedef union packed {
    logic [HDR_BYTES-1:0][7:0] bytes;
    struct packed {
      logic [7:0]  rsvd;    // Byte 7
      logic [7:0]  id;      // Byte 6
      logic [31:0] addr;    // Bytes 2 to 5 in little endian order
      logic [7:0]  len;     // Beats minus one
      logic [7:0]  opcode;  // Byte 0
    } f;
  } cmd_hdr_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [ID_W-1:0]   id;
  } mem_req_t;

  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } byte_beat_t;

  typedef struct packed {
    logic              last;
    logic [DATA_W-1:0] data;
  } word_beat_t;

endpackage

`default_nettype wire

/* verilog/cmd_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_parser (
  input  wire                         clock,
  input  wire                         rst_n_i,
  input  wire                         s_valid_i,
  output logic                        s_ready_o,
  input  wire memreq_pkg::byte_beat_t s_beat_i,
  output logic                        aw_valid_o,
  input  wire                         aw_ready_i,
  output memreq_pkg::mem_req_t        aw_o,
  output logic                        ar_valid_o,
  input  wire                         ar_ready_i,
  output memreq_pkg::mem_req_t        ar_o,
  output logic                        pl_valid_o,
  input  wire                         pl_ready_i,
  output memreq_pkg::byte_beat_t      pl_beat_o,
  output logic                        bad_valid_o,
  input  wire                         bad_ready_i,
  input  wire                         done_i
);

  import memreq_pkg::*;

  logic [2:0] state_q;
  logic [2:0] hdr_cnt_q;
  cmd_hdr_t   hdr_q;
  mem_req_t   req;
  logic       s_fire;

  // Same request drives both address channels
  assign req = '{addr: hdr_q.f.addr[ADDR_W-1:0],
                 len:  hdr_q.f.len,
                 id:   hdr_q.f.id[ID_W-1:0]};
  assign aw_o = req;
  assign ar_o = req;

  always_comb begin
    case (state_q)
      ST_HDR:     s_ready_o = 1'b1;
      ST_DRAIN:   s_ready_o = 1'b1;   // Discard everything up to last
      ST_PAYLOAD: s_ready_o = pl_ready_i;
      default:    s_ready_o = 1'b0;
    endcase
  end

  assign s_fire      = s_valid_i && s_ready_o;
  assign pl_valid_o  = (state_q == ST_PAYLOAD) && s_valid_i;
  assign pl_beat_o   = s_beat_i;   // Payload passes straight to the packer
  assign bad_valid_o = (state_q == ST_BAD);

  // Header bytes land in arrival order
  always_ff @(posedge clock) begin
    if (state_q == ST_HDR && s_fire) begin
      hdr_q.bytes[hdr_cnt_q] <= s_beat_i.data;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q    <= ST_HDR;
      hdr_cnt_q  <= '0;
      aw_valid_o <= 1'b0;
      ar_valid_o <= 1'b0;
    end else begin
      case (state_q)
        ST_HDR: begin
          if (s_fire) begin
            hdr_cnt_q <= hdr_cnt_q + 3'd1;
            if (hdr_cnt_q == 3'(HDR_BYTES - 1)) begin
              // Opcode arrived first, so it is already stored
              if (hdr_q.f.opcode == OP_WRITE) begin
                aw_valid_o <= 1'b1;
                state_q    <= ST_ADDR;
              end else if (hdr_q.f.opcode == OP_READ) begin
                ar_valid_o <= 1'b1;
                state_q    <= ST_ADDR;
              end else if (s_beat_i.last) begin
                state_q <= ST_BAD;
              end else begin
                state_q <= ST_DRAIN;
              end
            end
          end
        end
        ST_ADDR: begin
          if (aw_valid_o && aw_ready_i) begin
            aw_valid_o <= 1'b0;
            state_q    <= ST_PAYLOAD;
          end
          if (ar_valid_o && ar_ready_i) begin
            ar_valid_o <= 1'b0;
            state_q    <= ST_WAIT;   // Read data comes back through the mux
          end
        end
        ST_PAYLOAD: begin
          if (s_fire && s_beat_i.last) state_q <= ST_WAIT;
        end
        ST_DRAIN: begin
          if (s_fire && s_beat_i.last) state_q <= ST_BAD;
        end
        ST_BAD: begin
          if (bad_ready_i) state_q <= ST_WAIT;
        end
        ST_WAIT: begin
          if (done_i) state_q <= ST_HDR;   // Reply has fully left
        end
        default: state_q <= ST_HDR;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/byte_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_packer (
  input  wire                         clock,
  input  wire                         rst_n_i,
  input  wire                         pl_valid_i,
  output logic                        pl_ready_o,
  input  wire memreq_pkg::byte_beat_t pl_beat_i,
  output logic                        w_valid_o,
  input  wire                         w_ready_i,
  output memreq_pkg::word_beat_t      w_o
);

  import memreq_pkg::*;

  logic [1:0]        lane_q;
  logic [DATA_W-9:0] sh_q;   // First three bytes of the group
  logic              pl_fire;

  // Lane 3 also needs a free output word
  assign pl_ready_o = pl_valid_i && (lane_q != 2'd3 || !w_valid_o || w_ready_i);
  assign pl_fire    = pl_valid_i && pl_ready_o;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      lane_q    <= '0;
      w_valid_o <= 1'b0;
    end else begin
      if (w_valid_o && w_ready_i) w_valid_o <= 1'b0;
      if (pl_fire) begin
        lane_q <= lane_q + 2'd1;
        if (lane_q == 2'd3) w_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pl_fire) begin
      if (lane_q == 2'd3) begin
        w_o.data <= {pl_beat_i.data, sh_q};
        w_o.last <= pl_beat_i.last;   // Last byte closes the burst
      end else begin
        sh_q <= {pl_beat_i.data, sh_q[DATA_W-9:8]};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/word_unpacker.sv */
`timescale 1ns/100ps
`default_nettype none

module word_unpacker (
  input  wire                         clock,
  input  wire                         rst_n_i,
  input  wire                         r_valid_i,
  output logic                        r_ready_o,
  input  wire memreq_pkg::word_beat_t r_i,
  output logic                        rd_valid_o,
  input  wire                         rd_ready_i,
  output memreq_pkg::byte_beat_t      rd_beat_o
);

  import memreq_pkg::*;

  word_beat_t word_q;
  logic       full_q;
  logic [1:0] idx_q;       // Byte lane being emitted
  logic       last_byte;

  assign last_byte = (idx_q == 2'd3);

  assign rd_valid_o = full_q;
  assign rd_beat_o  = '{last: word_q.last && last_byte,
                        data: word_q.data[{idx_q, 3'b000} +: 8]};

  // Take a new word when empty or as byte 3 leaves
  assign r_ready_o = r_valid_i && (!full_q || (last_byte && rd_ready_i));

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (rd_valid_o && rd_ready_i) begin
        idx_q <= idx_q + 2'd1;   // Wraps to lane 0 for the next word
        if (last_byte) full_q <= 1'b0;
      end
      if (r_valid_i && r_ready_o) full_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (r_valid_i && r_ready_o) word_q <= r_i;
  end

endmodule

`default_nettype wire

/* verilog/reply_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module reply_mux (
  input  wire                          clock,
  input  wire                          rst_n_i,
  input  wire                          b_valid_i,
  output logic                         b_ready_o,
  input  wire [1:0]                    b_resp_i,
  input  wire [memreq_pkg::ID_W-1:0]   b_id_i,
  input  wire                          bad_valid_i,
  output logic                         bad_ready_o,
  input  wire                          rd_valid_i,
  output logic                         rd_ready_o,
  input  wire memreq_pkg::byte_beat_t  rd_beat_i,
  output logic                         m_valid_o,
  input  wire                          m_ready_i,
  output memreq_pkg::byte_beat_t       m_beat_o,
  output logic                         done_o
);

  import memreq_pkg::*;

  logic       lock_rd_q;   // Inside a read-data packet
  logic       load;
  logic       sel_b;
  logic       sel_bad;
  logic       sel_rd;
  byte_beat_t b_beat;
  byte_beat_t bad_beat;

  assign b_beat   = '{last: 1'b1, data: {b_id_i, 2'b00, b_resp_i}};
  assign bad_beat = '{last: 1'b1, data: {6'd0, RESP_BADCMD}};

  assign load = !m_valid_o || m_ready_i;   // Output register free

  // Fixed priority b, bad, read data, unless a read packet is open
  assign sel_b   = !lock_rd_q && b_valid_i;
  assign sel_bad = !lock_rd_q && !b_valid_i && bad_valid_i;
  assign sel_rd  = lock_rd_q || (!b_valid_i && !bad_valid_i);

  assign b_ready_o   = load && sel_b;
  assign bad_ready_o = load && sel_bad;
  assign rd_ready_o  = load && sel_rd && rd_valid_i;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      m_valid_o <= 1'b0;
      lock_rd_q <= 1'b0;
    end else begin
      if (b_ready_o || bad_ready_o || rd_ready_o) begin
        m_valid_o <= 1'b1;
      end else if (m_ready_i) begin
        m_valid_o <= 1'b0;
      end
      if (rd_ready_o) lock_rd_q <= !rd_beat_i.last;
    end
  end

  always_ff @(posedge clock) begin
    if (b_ready_o) begin
      m_beat_o <= b_beat;
    end else if (bad_ready_o) begin
      m_beat_o <= bad_beat;
    end else if (rd_ready_o) begin
      m_beat_o <= rd_beat_i;
    end
  end

  assign done_o = m_valid_o && m_ready_i && m_beat_o.last;

endmodule

`default_nettype wire

/* verilog/memreq_top.sv */
`timescale 1ns/100ps
`default_nettype none

module memreq_top (
  input  wire                          clock,
  input  wire                          rst_n_i,
  // Host link
  input  wire                          s_valid_i,
  output logic                         s_ready_o,
  input  wire memreq_pkg::byte_beat_t  s_beat_i,
  output logic                         m_valid_o,
  input  wire                          m_ready_i,
  output memreq_pkg::byte_beat_t       m_beat_o,
  // Memory controller
  output logic                         aw_valid_o,
  input  wire                          aw_ready_i,
  output memreq_pkg::mem_req_t         aw_o,
  output logic                         w_valid_o,
  input  wire                          w_ready_i,
  output memreq_pkg::word_beat_t       w_o,
  input  wire                          b_valid_i,
  output logic                         b_ready_o,
  input  wire [1:0]                    b_resp_i,
  input  wire [memreq_pkg::ID_W-1:0]   b_id_i,
  output logic                         ar_valid_o,
  input  wire                          ar_ready_i,
  output memreq_pkg::mem_req_t         ar_o,
  input  wire                          r_valid_i,
  output logic                         r_ready_o,
  input  wire memreq_pkg::word_beat_t  r_i
);

  import memreq_pkg::*;

  logic       pl_valid;
  logic       pl_ready;
  byte_beat_t pl_beat;    // Write payload bytes
  logic       rd_valid;
  logic       rd_ready;
  byte_beat_t rd_beat;    // Read data bytes
  logic       bad_valid;
  logic       bad_ready;
  logic       done;

  cmd_parser u_parser (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .s_beat_i    (s_beat_i),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_o        (aw_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_o        (ar_o),
    .pl_valid_o  (pl_valid),
    .pl_ready_i  (pl_ready),
    .pl_beat_o   (pl_beat),
    .bad_valid_o (bad_valid),
    .bad_ready_i (bad_ready),
    .done_i      (done)
  );

  byte_packer u_packer (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .pl_valid_i (pl_valid),
    .pl_ready_o (pl_ready),
    .pl_beat_i  (pl_beat),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_o        (w_o)
  );

  word_unpacker u_unpacker (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_i        (r_i),
    .rd_valid_o (rd_valid),
    .rd_ready_i (rd_ready),
    .rd_beat_o  (rd_beat)
  );

  reply_mux u_mux (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .b_resp_i    (b_resp_i),
    .b_id_i      (b_id_i),
    .bad_valid_i (bad_valid),
    .bad_ready_o (bad_ready),
    .rd_valid_i  (rd_valid),
    .rd_ready_o  (rd_ready),
    .rd_beat_i   (rd_beat),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_beat_o    (m_beat_o),
    .done_o      (done)
  );

endmodule

`default_nettype wire

/* tb/memreq_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module memreq_chk (
  input wire                         clock,
  input wire                         rst_n_i,
  input wire                         m_valid_o,
  input wire                         m_ready_i,
  input wire memreq_pkg::byte_beat_t m_beat_o,
  input wire                         aw_valid_o,
  input wire                         aw_ready_i,
  input wire memreq_pkg::mem_req_t   aw_o,
  input wire                         w_valid_o,
  input wire                         w_ready_i,
  input wire memreq_pkg::word_beat_t w_o,
  input wire                         ar_valid_o,
  input wire                         ar_ready_i,
  input wire memreq_pkg::mem_req_t   ar_o
);

  // Held beats stay put until taken
  a_m_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
    else $error("host reply beat changed before handshake");
  a_aw_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("aw request changed before handshake");
  a_w_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("w beat changed before handshake");
  a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("ar request changed before handshake");

  // Outputs settle one edge into reset
  a_rst_quiet: assert property (@(posedge clock)
    !rst_n_i |=> !(m_valid_o || aw_valid_o || w_valid_o || ar_valid_o))
    else $error("valid output high during reset");

endmodule

bind memreq_top memreq_chk u_chk (.*);

`default_nettype wire

/* tb/tb_memreq.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_memreq;

  import memreq_pkg::*;

  logic       clock = 1'b0;
  logic       rst_n_i;
  logic       s_valid_i;
  logic       s_ready_o;
  byte_beat_t s_beat_i;
  logic       m_valid_o;
  logic       m_ready_i = 1'b0;
  byte_beat_t m_beat_o;
  logic       aw_valid_o;
  logic       aw_ready_i = 1'b0;
  mem_req_t   aw_o;
  logic       w_valid_o;
  logic       w_ready_i = 1'b0;
  word_beat_t w_o;
  logic       b_valid_i = 1'b0;
  logic       b_ready_o;
  logic [1:0] b_resp_i = 2'd0;
  logic [3:0] b_id_i = 4'd0;
  logic       ar_valid_o;
  logic       ar_ready_i = 1'b0;
  mem_req_t   ar_o;
  logic       r_valid_i = 1'b0;
  logic       r_ready_o;
  word_beat_t r_i = '0;

  // Handshakes seen at the rising edge
  logic s_fire_q, aw_fire_q, w_fire_q, b_fire_q, ar_fire_q, r_fire_q;
  mem_req_t   aw_cap_q;
  mem_req_t   ar_cap_q;
  word_beat_t w_cap_q;

  logic [31:0] mem [0:255];
  logic [7:0]  ref_mem [0:1023];   // Expected contents by byte address
  logic [7:0]  pay [0:63];
  logic [7:0]  wr_idx, rd_idx;
  logic [8:0]  rd_left = 9'd0;
  logic        wr_err;
  logic [3:0]  wr_id;
  mem_req_t    exp_aw;   // Request the next write should issue
  mem_req_t    exp_ar;
  string       test_name = "";
  logic [31:0] data_lfsr = 32'hdbab_04c6;
  logic [31:0] bp_lfsr = 32'hdbab_04c6;
  byte_beat_t  rx_q[$];
  byte_beat_t  exp_q[$];
  int          errors = 0;
  int          timeouts = 0;

  memreq_top UUT (.*);

  always #10 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
  endfunction

  task automatic next_byte(output logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      data_lfsr = lfsr_step(data_lfsr);
      v[i] = data_lfsr[0];
    end
  endtask

  // Ready high three times in four
  task automatic draw_ready(output logic r);
    logic a;
    bp_lfsr = lfsr_step(bp_lfsr);
    a = bp_lfsr[0];
    bp_lfsr = lfsr_step(bp_lfsr);
    r = a | bp_lfsr[0];
  endtask

  always @(posedge clock) begin
    if (m_valid_o && m_ready_i) rx_q.push_back(m_beat_o);   // Reply collector
    s_fire_q  <= s_valid_i && s_ready_o;
    aw_fire_q <= aw_valid_o && aw_ready_i;
    aw_cap_q  <= aw_o;
    w_fire_q  <= w_valid_o && w_ready_i;
    w_cap_q   <= w_o;
    b_fire_q  <= b_valid_i && b_ready_o;
    ar_fire_q <= ar_valid_o && ar_ready_i;
    ar_cap_q  <= ar_o;
    r_fire_q  <= r_valid_i && r_ready_o;
  end

  // Memory model
  always @(negedge clock) begin
    if (!rst_n_i) begin
      b_valid_i  = 1'b0;
      r_valid_i  = 1'b0;
      rd_left    = 9'd0;
      aw_ready_i = 1'b0;
      w_ready_i  = 1'b0;
      ar_ready_i = 1'b0;
      m_ready_i  = 1'b0;
    end else begin
      if (aw_fire_q) begin
        if (aw_cap_q !== exp_aw) begin
          $display("ERR %s aw request: expected %h, actual %h", test_name, exp_aw, aw_cap_q);
          errors++;
        end
        wr_idx = aw_cap_q.addr[9:2];
        wr_err = aw_cap_q.addr >= 28'h400;
        wr_id  = aw_cap_q.id;
      end
      if (b_fire_q) b_valid_i = 1'b0;
      if (w_fire_q) begin
        if (!wr_err) mem[wr_idx] = w_cap_q.data;
        wr_idx = wr_idx + 8'd1;
        if (w_cap_q.last) begin
          b_valid_i = 1'b1;
          b_resp_i  = wr_err ? RESP_SLVERR : RESP_OKAY;
          b_id_i    = wr_id;
        end
      end
      if (ar_fire_q) begin
        if (ar_cap_q !== exp_ar) begin
          $display("ERR %s ar request: expected %h, actual %h", test_name, exp_ar, ar_cap_q);
          errors++;
        end
        rd_idx  = ar_cap_q.addr[9:2];
        rd_left = {1'b0, ar_cap_q.len} + 9'd1;
      end
      if (r_fire_q) begin
        rd_idx  = rd_idx + 8'd1;
        rd_left = rd_left - 9'd1;
      end
      r_valid_i = (rd_left != 9'd0);
      r_i.data  = mem[rd_idx];
      r_i.last  = (rd_left == 9'd1);
      draw_ready(aw_ready_i);
      draw_ready(w_ready_i);
      draw_ready(ar_ready_i);
      draw_ready(m_ready_i);
    end
  end

  task automatic send_byte(input logic [7:0] data, input logic last);
    int t;
    t = 0;
    s_valid_i     = 1'b1;
    s_beat_i.data = data;
    s_beat_i.last = last;
    do begin
      @(negedge clock);
      t++;
    end while (!s_fire_q && t < 500);
    if (!s_fire_q) begin
      $display("Host byte %h was never accepted by the DUT", data);
      timeouts++;
    end
    s_valid_i = 1'b0;
  endtask

  task automatic send_header(input logic [7:0] op, input logic [7:0] len,
                             input logic [31:0] addr, input logic [3:0] id,
                             input logic last);
    send_byte(op, 1'b0);
    send_byte(len, 1'b0);
    for (int i = 0; i < 4; i++) send_byte(addr[8*i +: 8], 1'b0);
    send_byte({4'd0, id}, 1'b0);
    send_byte(8'h00, last);   // Reserved byte
  endtask

  // Payload comes from pay[] and the status byte is queued as expected
  task automatic write_cmd(input logic [31:0] addr, input logic [7:0] len,
                           input logic [3:0] id);
    int n;
    logic [1:0] resp;
    n      = (len + 1) * 4;
    resp   = (addr >= 32'h400) ? RESP_SLVERR : RESP_OKAY;
    exp_aw = '{addr: addr[ADDR_W-1:0], len: len, id: id};
    send_header(OP_WRITE, len, addr, id, 1'b0);
    for (int i = 0; i < n; i++) begin
      send_byte(pay[i], i == n - 1);
      if (addr < 32'h400) ref_mem[addr[9:0] + 10'(i)] = pay[i];
    end
    exp_q.push_back('{last: 1'b1, data: {id, 2'b00, resp}});
  endtask

  task automatic read_cmd(input logic [31:0] addr, input logic [7:0] len,
                          input logic [3:0] id);
    int n;
    n      = (len + 1) * 4;
    exp_ar = '{addr: addr[ADDR_W-1:0], len: len, id: id};
    send_header(OP_READ, len, addr, id, 1'b1);
    for (int i = 0; i < n; i++) begin
      exp_q.push_back('{last: (i == n - 1), data: ref_mem[addr[9:0] + 10'(i)]});
    end
  endtask

  task automatic check_replies(input string name);
    int t;
    int n;
    byte_beat_t got;
    byte_beat_t want;
    t = 0;
    while (rx_q.size() < exp_q.size() && t < 3000) begin
      @(negedge clock);
      t++;
    end
    if (rx_q.size() < exp_q.size()) begin
      $display("%s: reply stopped after %0d of %0d bytes", name, rx_q.size(), exp_q.size());
      timeouts++;
    end
    n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      got  = rx_q.pop_front();
      want = exp_q.pop_front();
      if (got !== want) begin
        $display("ERR %s byte %0d {last,data}: expected %h, actual %h", name, i, want, got);
        errors++;
      end
    end
    repeat (10) @(negedge clock);
    if (rx_q.size() != 0) begin
      $display("%s: DUT sent %0d bytes more than expected", name, rx_q.size());
      errors++;
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic single_write_read();
    test_name = "single_write_read";
    pay[0] = 8'h11;
    pay[1] = 8'h22;
    pay[2] = 8'h33;
    pay[3] = 8'h44;
    write_cmd(32'h10, 8'd0, 4'h3);
    read_cmd(32'h10, 8'd0, 4'h3);
    check_replies(test_name);
  endtask

  task automatic burst_readback();
    test_name = "burst16";
    for (int i = 0; i < 64; i++) next_byte(pay[i]);
    write_cmd(32'h100, 8'd15, 4'h5);
    read_cmd(32'h100, 8'd15, 4'h6);
    check_replies(test_name);
  endtask

  task automatic slverr_write();
    test_name = "slverr";
    pay[0] = 8'hde;
    pay[1] = 8'had;
    pay[2] = 8'hbe;
    pay[3] = 8'hef;
    write_cmd(32'h400, 8'd0, 4'h9);
    check_replies(test_name);
  endtask

  task automatic bad_opcode_drain();
    test_name = "bad_opcode";
    send_header(8'h7f, 8'd0, 32'h10, 4'h2, 1'b0);
    send_byte(8'haa, 1'b0);
    send_byte(8'hbb, 1'b0);
    send_byte(8'hcc, 1'b1);
    exp_q.push_back('{last: 1'b1, data: 8'h03});
    read_cmd(32'h10, 8'd0, 4'h1);
    check_replies(test_name);
  endtask

  task automatic back_to_back_ids();
    test_name = "back_to_back";
    for (int i = 0; i < 4; i++) next_byte(pay[i]);
    write_cmd(32'h20, 8'd0, 4'h1);
    for (int i = 0; i < 4; i++) next_byte(pay[i]);
    write_cmd(32'h24, 8'd0, 4'h2);
    read_cmd(32'h20, 8'd1, 4'h4);
    check_replies(test_name);
  endtask

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = {~i[7:0], i[7:0], 8'h5a ^ i[7:0], i[7:0]};
    rst_n_i   = 1'b0;
    s_valid_i = 1'b0;
    s_beat_i  = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    rst_n_i = 1'b1;
    @(negedge clock);
    single_write_read();
    burst_readback();
    slverr_write();
    bad_opcode_drain();
    back_to_back_ids();
    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
verilog/memreq_pkg.sv
verilog/cmd_parser.sv
verilog/byte_packer.sv
verilog/word_unpacker.sv
verilog/reply_mux.sv
verilog/memreq_top.sv
tb/memreq_chk.sv
tb/tb_memreq.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_memreq -o sim_memreq
./obj_dir/sim_memreq | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
